//--- Bender.yml
package:
  name: line_cache

sources:
  - files:
      - hdl/line_cache_pkg.sv
      - hdl/bank_router.sv
      - hdl/line_memory.sv
      - hdl/line_rmw_bank.sv
      - hdl/bank_collector.sv
      - hdl/line_cache_top.sv
  - target: simulation
    files:
      - bench/line_cache_tb.sv

//--- bench/line_cache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module line_cache_tb;

  localparam int LINE_SIZE      = 16;
  localparam int NUM_BANKS      = 4;
  localparam int LINES_PER_BANK = 64;
  localparam int MEM_LATENCY    = 3;

  localparam int WORDS    = LINE_SIZE / 4;
  localparam int OFF_W    = $clog2(WORDS);
  localparam int BANK_W   = $clog2(NUM_BANKS);
  localparam int IDX_W    = $clog2(LINES_PER_BANK);
  localparam int BANK_LSB = 2 + OFF_W;
  localparam int IDX_LSB  = BANK_LSB + BANK_W;
  localparam int HIGH_LSB = IDX_LSB + IDX_W;

  localparam int          ACK_TIMEOUT = 20;
  localparam int          NUM_TRANS   = 400;
  localparam logic [31:0] SEED        = 32'hc2fb2aff;

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  logic [31:0] lfsr_state;
  // Expected word for each (line, bank, offset); missing keys read as zero.
  logic [31:0] model [int];

  line_cache_top line_cache_top_i (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  // One LFSR step per bit taken.
  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [31:0] make_addr(input int idx, input int bank, input int off,
                                            input int high, input int low);
    return (32'(high) << HIGH_LSB) | (32'(idx) << IDX_LSB) | (32'(bank) << BANK_LSB) |
           (32'(off) << 2) | 32'(low);
  endfunction

  function automatic int model_key(input logic [31:0] adr);
    int off;
    int bank;
    int idx;
    off  = (adr >> 2) % WORDS;
    bank = (adr >> BANK_LSB) % NUM_BANKS;
    idx  = (adr >> IDX_LSB) % LINES_PER_BANK;
    return (idx * NUM_BANKS + bank) * WORDS + off;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] adr);
    int key;
    key = model_key(adr);
    if (model.exists(key)) begin
      return model[key];
    end
    return 32'h0;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      fail_now($sformatf("FAIL at %0t: %s, got %h, expected %h",
                         $time, what, got, expected));
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      check_value("acknowledge while idle", 32'(wb_ack), 32'd0);
    end
  endtask

  // One classic cycle, held until the acknowledge.
  task automatic access(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                        output logic [31:0] rdata);
    int   cycles;
    logic got_ack;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    cycles  = 0;
    got_ack = 1'b0;
    while (!got_ack && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      got_ack = wb_ack;
    end
    if (!got_ack) begin
      fail_now($sformatf("No acknowledge arrived within %0d cycles of the request at %0t.",
                         ACK_TIMEOUT, $time));
    end
    rdata = wb_dat_r;
    // Ack rose on the edge one cycle before the negedge that saw it.
    if (!we) begin
      check_value("read acknowledged too early", 32'(cycles - 1 >= MEM_LATENCY + 2), 32'd1);
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk);
    check_value("second acknowledge for one request", 32'(wb_ack), 32'd0);
  endtask

  task automatic write_word(input logic [31:0] adr, input logic [31:0] data);
    logic [31:0] ignored;
    access(1'b1, adr, data, ignored);
    model[model_key(adr)] = data;
  endtask

  task automatic check_read(input logic [31:0] adr, input string what);
    logic [31:0] rd;
    access(1'b0, adr, 32'h0, rd);
    check_value($sformatf("%s at %h", what, adr), rd, model_read(adr));
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] we_bit;
    logic [31:0] idx;
    logic [31:0] bank;
    logic [31:0] off;
    logic [31:0] high;
    logic [31:0] low;
    logic [31:0] adr;
    logic [31:0] bank_data [NUM_BANKS];

    reset      = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = 32'h0;
    wb_dat_w   = 32'h0;
    lfsr_state = SEED;

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    idle_cycles(6);

    // Outside the random line range, so never written.
    access(1'b0, make_addr(40, 1, 3, 0, 0), 32'h0, rd);
    check_value("word never written", rd, 32'h0);

    // Same line and offset in every bank.
    for (int b = 0; b < NUM_BANKS; b++) begin
      draw_bits(32, data);
      bank_data[b] = data;
      write_word(make_addr(5, b, 2, 0, 0), data);
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      access(1'b0, make_addr(5, b, 2, 0, 0), 32'h0, rd);
      check_value("bank kept its own word", rd, bank_data[b]);
      access(1'b0, make_addr(5, b, 2, 5, 3), 32'h0, rd);
      check_value("alias above the line index", rd, bank_data[b]);
    end
    idle_cycles(3);

    for (int t = 0; t < NUM_TRANS; t++) begin
      draw_bits(1, we_bit);
      draw_bits(3, idx);
      draw_bits(BANK_W, bank);
      draw_bits(OFF_W, off);
      draw_bits(3, high);
      draw_bits(2, low);
      adr = make_addr(idx, bank, off, high, low);
      if (we_bit[0]) begin
        draw_bits(32, data);
        write_word(adr, data);
        draw_bits(3, high);
        access(1'b0, make_addr(idx, bank, off, high, 0), 32'h0, rd);
        check_value("read back after write", rd, data);
        // The rest of the line must survive the read-modify-write.
        for (int w = 0; w < WORDS; w++) begin
          if (w != off) begin
            check_read(make_addr(idx, bank, w, 0, 0), "neighbour word after write");
          end
        end
      end else begin
        check_read(adr, "random read");
      end
    end
    idle_cycles(4);

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/bank_collector.sv
`timescale 1ns/100ps
`default_nettype none

module bank_collector #(
  parameter int NUM_BANKS = 4
) (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic [NUM_BANKS-1:0]                                  bank_done,
  input  logic [NUM_BANKS-1:0][line_cache_pkg::WORD_WIDTH-1:0]  bank_rdata,
  output logic                                                  wb_ack,
  output logic [line_cache_pkg::WORD_WIDTH-1:0]                 wb_dat_r,
  output logic                                                  cycle_done
);

  import line_cache_pkg::*;

  logic                  any_done;
  logic [WORD_WIDTH-1:0] done_data;

  assign any_done = |bank_done;

  // Only one bank finishes at a time, so an OR of masked data is enough.
  always_comb begin
    done_data = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (bank_done[i]) begin
        done_data |= bank_rdata[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= any_done;
    end
  end

  always_ff @(posedge clk) begin
    if (any_done) begin
      wb_dat_r <= done_data;
    end
  end

  assign cycle_done = wb_ack;

  a_single_done: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(bank_done)
  ) else $error("Two banks completed in the same cycle.");

endmodule

`default_nettype wire

//--- hdl/bank_router.sv
`timescale 1ns/100ps
`default_nettype none

module bank_router #(
  parameter int LINE_SIZE = 16,
  parameter int NUM_BANKS = 4
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   wb_cyc,
  input  logic                                   wb_stb,
  input  logic                                   wb_we,
  input  logic [31:0]                            wb_adr,
  input  logic [line_cache_pkg::WORD_WIDTH-1:0]  wb_dat_w,
  input  logic                                   cycle_done,
  output logic [NUM_BANKS-1:0]                   bank_start,
  output logic [31:0]                            req_addr,
  output logic                                   req_write,
  output logic [line_cache_pkg::WORD_WIDTH-1:0]  req_data
);

  localparam int OFF_W    = $clog2(LINE_SIZE / 4);
  localparam int BANK_W   = $clog2(NUM_BANKS);
  localparam int BANK_LSB = 2 + OFF_W;

  logic              busy;
  logic              capture;
  logic [BANK_W-1:0] bank_sel;

  // Only one request in flight.
  assign capture  = wb_cyc && wb_stb && !busy;
  assign bank_sel = wb_adr[BANK_LSB +: BANK_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      bank_start <= '0;
    end else begin
      // One-cycle start to the bank picked by the address.
      if (capture) begin
        bank_start <= NUM_BANKS'(1) << bank_sel;
      end else begin
        bank_start <= '0;
      end

      if (capture) begin
        busy <= 1'b1;
      end else if (cycle_done) begin
        busy <= 1'b0;
      end
    end
  end

  // Request fields stay put until the next capture.
  always_ff @(posedge clk) begin
    if (capture) begin
      req_addr  <= wb_adr;
      req_write <= wb_we;
      req_data  <= wb_dat_w;
    end
  end

  a_start_onehot: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(bank_start)
  ) else $error("More than one bank started in one cycle.");

  // Collector must only finish a request that was captured here.
  a_done_when_busy: assert property (
    @(posedge clk) disable iff (reset)
    cycle_done |-> busy
  ) else $error("cycle_done seen with no request in flight.");

endmodule

`default_nettype wire

//--- hdl/line_cache_pkg.sv
`default_nettype none

package line_cache_pkg;

  // Width of one Wishbone data word.
  localparam int WORD_WIDTH = 32;

  // Bank controller states.
  // A write walks through both WRITE states, a read uses READ only.
  typedef enum logic [1:0] {
    STANDBY,
    READ,
    WRITE_READ,
    WRITE_WRITE
  } bank_state_e;

endpackage

`default_nettype wire

//--- hdl/line_cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module line_cache_top #(
  parameter int LINE_SIZE      = 16,
  parameter int NUM_BANKS      = 4,
  parameter int LINES_PER_BANK = 64,
  parameter int MEM_LATENCY    = 3
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   wb_cyc,
  input  logic                                   wb_stb,
  input  logic                                   wb_we,
  input  logic [31:0]                            wb_adr,
  input  logic [line_cache_pkg::WORD_WIDTH-1:0]  wb_dat_w,
  output logic [line_cache_pkg::WORD_WIDTH-1:0]  wb_dat_r,
  output logic                                   wb_ack
);

  import line_cache_pkg::*;

  logic [NUM_BANKS-1:0]                 bank_start;
  logic [31:0]                          req_addr;
  logic                                 req_write;
  logic [WORD_WIDTH-1:0]                req_data;
  logic [NUM_BANKS-1:0]                 bank_done;
  logic [NUM_BANKS-1:0][WORD_WIDTH-1:0] bank_rdata;
  logic                                 cycle_done;

  bank_router #(
    .LINE_SIZE (LINE_SIZE),
    .NUM_BANKS (NUM_BANKS)
  ) bank_router_i (
    .clk        (clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .cycle_done (cycle_done),
    .bank_start (bank_start),
    .req_addr   (req_addr),
    .req_write  (req_write),
    .req_data   (req_data)
  );

  // All banks see the same request fields, start picks one.
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    line_rmw_bank #(
      .LINE_SIZE      (LINE_SIZE),
      .NUM_BANKS      (NUM_BANKS),
      .LINES_PER_BANK (LINES_PER_BANK),
      .MEM_LATENCY    (MEM_LATENCY)
    ) line_rmw_bank_i (
      .clk   (clk),
      .reset (reset),
      .start (bank_start[i]),
      .addr  (req_addr),
      .write (req_write),
      .wdata (req_data),
      .done  (bank_done[i]),
      .rdata (bank_rdata[i])
    );
  end

  bank_collector #(
    .NUM_BANKS (NUM_BANKS)
  ) bank_collector_i (
    .clk        (clk),
    .reset      (reset),
    .bank_done  (bank_done),
    .bank_rdata (bank_rdata),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r),
    .cycle_done (cycle_done)
  );

endmodule

`default_nettype wire

//--- hdl/line_memory.sv
`timescale 1ns/100ps
`default_nettype none

module line_memory #(
  parameter int LINE_SIZE      = 16,
  parameter int LINES_PER_BANK = 64,
  parameter int MEM_LATENCY    = 3
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               mem_req,
  input  logic                               mem_read,
  input  logic                               mem_write,
  input  logic [$clog2(LINES_PER_BANK)-1:0]  mem_line_addr,
  input  logic [LINE_SIZE*8-1:0]             mem_wdata,
  output logic                               mem_rvalid,
  output logic [LINE_SIZE*8-1:0]             mem_rdata,
  output logic                               mem_ready
);

  localparam int LINE_BITS = LINE_SIZE * 8;
  localparam int IDX_W     = $clog2(LINES_PER_BANK);
  localparam int CNT_W     = $clog2(MEM_LATENCY + 1);

  logic [LINE_BITS-1:0] lines [LINES_PER_BANK];

  logic             busy;
  logic [CNT_W-1:0] count;
  logic             op_read;
  logic             op_write;
  logic [IDX_W-1:0] op_addr;
  logic [LINE_BITS-1:0] op_data;
  logic             accept;
  logic             fire;

  initial begin
    for (int i = 0; i < LINES_PER_BANK; i++) begin
      lines[i] = '0;
    end
  end

  assign accept = mem_req && !busy;
  // Access happens MEM_LATENCY cycles after acceptance.
  assign fire   = busy && (count == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      count    <= '0;
      op_read  <= 1'b0;
      op_write <= 1'b0;
    end else if (accept) begin
      busy     <= 1'b1;
      count    <= CNT_W'(MEM_LATENCY - 1);
      op_read  <= mem_read;
      op_write <= mem_write;
    end else if (busy) begin
      if (count == '0) begin
        busy <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_addr <= mem_line_addr;
      op_data <= mem_wdata;
    end
  end

  always @(posedge clk) begin
    if (fire && op_write) begin
      lines[op_addr] <= op_data;
    end
  end

  assign mem_rvalid = fire && op_read;
  assign mem_ready  = fire && op_write;
  assign mem_rdata  = lines[op_addr];

  // Bank must wait for rvalid or ready before the next request.
  a_no_req_when_busy: assert property (
    @(posedge clk) disable iff (reset)
    busy |-> !mem_req
  ) else $error("Memory request issued while an access is pending.");

endmodule

`default_nettype wire

//--- hdl/line_rmw_bank.sv
`timescale 1ns/100ps
`default_nettype none

module line_rmw_bank #(
  parameter int LINE_SIZE      = 16,
  parameter int NUM_BANKS      = 4,
  parameter int LINES_PER_BANK = 64,
  parameter int MEM_LATENCY    = 3
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   start,
  input  logic [31:0]                            addr,
  input  logic                                   write,
  input  logic [line_cache_pkg::WORD_WIDTH-1:0]  wdata,
  output logic                                   done,
  output logic [line_cache_pkg::WORD_WIDTH-1:0]  rdata
);

  import line_cache_pkg::*;

  localparam int LINE_BITS = LINE_SIZE * 8;
  localparam int WORDS     = LINE_BITS / WORD_WIDTH;
  localparam int OFF_W     = $clog2(WORDS);
  localparam int BANK_W    = $clog2(NUM_BANKS);
  localparam int IDX_W     = $clog2(LINES_PER_BANK);
  localparam int IDX_LSB   = 2 + OFF_W + BANK_W;

  bank_state_e state;
  bank_state_e next_state;

  logic [OFF_W-1:0] word_off;
  logic [IDX_W-1:0] line_idx;

  logic                 mem_req;
  logic                 mem_read;
  logic                 mem_write;
  logic                 mem_rvalid;
  logic                 mem_ready;
  logic [LINE_BITS-1:0] mem_rdata;
  logic [LINE_BITS-1:0] line_buf;
  logic                 wr_pending;

  logic [WORDS-1:0][WORD_WIDTH-1:0] fetched_words;
  logic [WORDS-1:0][WORD_WIDTH-1:0] merged_words;

  // The router holds addr and wdata for the whole request.
  assign word_off      = addr[2 +: OFF_W];
  assign line_idx      = addr[IDX_LSB +: IDX_W];
  assign fetched_words = mem_rdata;

  // Fetched line with the addressed word replaced.
  always_comb begin
    merged_words           = fetched_words;
    merged_words[word_off] = wdata;
  end

  always_comb begin
    next_state = state;
    mem_req    = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    case (state)
      STANDBY: begin
        if (start) begin
          mem_req    = 1'b1;
          mem_read   = 1'b1;
          next_state = write ? WRITE_READ : READ;
        end
      end
      READ: begin
        if (mem_rvalid) begin
          next_state = STANDBY;
        end
      end
      WRITE_READ: begin
        if (mem_rvalid) begin
          next_state = WRITE_WRITE;
        end
      end
      WRITE_WRITE: begin
        // Write-back goes out once, on the first cycle here.
        if (wr_pending) begin
          mem_req   = 1'b1;
          mem_write = 1'b1;
        end
        if (mem_ready) begin
          next_state = STANDBY;
        end
      end
      default: next_state = STANDBY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= STANDBY;
      wr_pending <= 1'b0;
      done       <= 1'b0;
    end else begin
      state      <= next_state;
      wr_pending <= (state == WRITE_READ) && mem_rvalid;
      done       <= ((state == READ) && mem_rvalid) ||
                    ((state == WRITE_WRITE) && mem_ready);
    end
  end

  always_ff @(posedge clk) begin
    if ((state == READ) && mem_rvalid) begin
      rdata <= fetched_words[word_off];
    end
    if ((state == WRITE_READ) && mem_rvalid) begin
      line_buf <= merged_words;
    end
  end

  line_memory #(
    .LINE_SIZE      (LINE_SIZE),
    .LINES_PER_BANK (LINES_PER_BANK),
    .MEM_LATENCY    (MEM_LATENCY)
  ) line_memory_i (
    .clk           (clk),
    .reset         (reset),
    .mem_req       (mem_req),
    .mem_read      (mem_read),
    .mem_write     (mem_write),
    .mem_line_addr (line_idx),
    .mem_wdata     (line_buf),
    .mem_rvalid    (mem_rvalid),
    .mem_rdata     (mem_rdata),
    .mem_ready     (mem_ready)
  );

  a_start_in_standby: assert property (
    @(posedge clk) disable iff (reset)
    start |-> state == STANDBY
  ) else $error("Bank started while a request is still running.");

  a_read_write_excl: assert property (
    @(posedge clk) disable iff (reset)
    !(mem_read && mem_write)
  ) else $error("Memory read and write requested together.");

endmodule

`default_nettype wire

//--- line_cache_top.f
hdl/line_cache_pkg.sv
hdl/bank_router.sv
hdl/line_memory.sv
hdl/line_rmw_bank.sv
hdl/bank_collector.sv
hdl/line_cache_top.sv
bench/line_cache_tb.sv
